// ==== openCLFullPipeline.f ====
+incdir+include
hw/dedekindPkg.sv
hw/botIntake.sv
hw/componentCounter.sv
hw/pcoeffAccumulator.sv
hw/openCLFullPipeline.sv
bench/openCLFullPipelineTb.sv

// ==== build.sh ====
#!/bin/sh
# Builds the testbench with Verilator and runs it; a $fatal gives a failing exit status
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f openCLFullPipeline.f \
    --top-module openCLFullPipelineTb \
    -o openCLFullPipelineSim

./obj_dir/openCLFullPipelineSim

// ==== include/dedekindRefModel.svh ====
`ifndef DEDEKIND_REF_MODEL_SVH
`define DEDEKIND_REF_MODEL_SVH

// Vertex set of one item given the top in force before it
function automatic logic [botWidth-1:0] formMask(
    input logic                newTop,
    input logic [botWidth-1:0] top,
    input logic [botWidth-1:0] bot
);
    logic [botWidth-1:0] m;
    if (newTop) begin
        m = bot;                             // A new top is its own graph
    end else begin
        m = top & ~bot;                      // Set in top, clear in bot
    end
    return m;
endfunction

// Depth-first flood fill over the 7-cube, stops at maxCount components
function automatic int countComponents(input logic [botWidth-1:0] mask);
    logic [botWidth-1:0] left;
    int                  stack [botWidth];
    int                  sp;
    int                  comps;
    int                  v;
    int                  n;
    left  = mask;
    comps = 0;
    for (int s = 0; s < botWidth; s++) begin
        if (left[s] && comps < maxCount) begin
            comps++;
            left[s]  = 1'b0;
            stack[0] = s;
            sp       = 1;
            while (sp > 0) begin
                sp--;
                v = stack[sp];
                for (int d = 0; d < cubeDims; d++) begin
                    n = v ^ (1 << d);        // Neighbour across dimension d
                    if (left[n]) begin
                        left[n]   = 1'b0;
                        stack[sp] = n;
                        sp++;
                    end
                end
            end
        end
    end
    return comps;
endfunction

// Running sum of 2^count, restarted by a new top
function automatic logic [sumWidth-1:0] addTerm(
    input logic [sumWidth-1:0] prevSum,
    input logic                newTop,
    input int                  count
);
    longint term;
    term = 1;
    repeat (count) term = term * 2;
    if (newTop) begin
        return sumWidth'(term);
    end
    return prevSum + sumWidth'(term);
endfunction

`endif

// ==== bench/openCLFullPipelineTb.sv ====
`timescale 1ns/1ps

module openCLFullPipelineTb;
    import dedekindPkg::*;

    `include "dedekindRefModel.svh"

    localparam int clkPeriod     = 8;
    localparam int directedItems = 12;
    localparam int burstItems    = 40;
    localparam int randomItems   = 400;
    localparam int itemBudget    = directedItems + burstItems + randomItems;
    localparam int worstLatency  = maxCount * 9 + 2;           // Cycles per item at most
    localparam int watchdogNs    = 10 * itemBudget * worstLatency * clkPeriod;

    logic                clk;
    logic                rst;
    logic                ivalid;
    logic                startNewTop;
    logic [botWidth-1:0] bot;
    logic                oready;
    logic                ovalid;
    pcoeffResult         result;

    integer              seed;
    logic [31:0]         r;
    logic [botWidth-1:0] w;

    // Scoreboard state
    pcoeffResult         expQ [$];
    pcoeffResult         head;
    pcoeffResult         pushed;
    logic [botWidth-1:0] refTop;
    logic [botWidth-1:0] refMask;
    logic [sumWidth-1:0] refSum;
    int                  refCount;

    openCLFullPipeline u_openCLFullPipeline (
        .clk         (clk),
        .rst         (rst),
        .ivalid      (ivalid),
        .startNewTop (startNewTop),
        .bot         (bot),
        .oready      (oready),
        .ovalid      (ovalid),
        .result      (result)
    );

    initial begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    // Random 128-bit word, density 0 sparse up to 3 dense
    function automatic logic [botWidth-1:0] randomWord(input int density);
        logic [botWidth-1:0] word;
        logic [31:0]         a;
        logic [31:0]         b;
        logic [31:0]         c;
        for (int i = 0; i < botWidth / 32; i++) begin
            a = $random(seed);
            b = $random(seed);
            c = $random(seed);
            case (density)
                0:       word[i*32 +: 32] = a & b & c;
                1:       word[i*32 +: 32] = a & b;
                2:       word[i*32 +: 32] = a;
                default: word[i*32 +: 32] = a | b;
            endcase
        end
        return word;
    endfunction

    // All vertices of one parity, none of them adjacent
    function automatic logic [botWidth-1:0] parityVertices(input logic odd);
        logic [botWidth-1:0] word;
        logic [cubeDims-1:0] idx;
        for (int v = 0; v < botWidth; v++) begin
            idx     = cubeDims'(v);
            word[v] = ((^idx) == odd);
        end
        return word;
    endfunction

    // Hold the item until the DUT takes it
    task automatic offerItem(input logic newTop, input logic [botWidth-1:0] word);
        logic taken;
        ivalid      = 1'b1;
        startNewTop = newTop;
        bot         = word;
        taken       = 1'b0;
        while (!taken) begin
            @(negedge clk);
            taken = oready;                  // Accepted at the coming edge
            @(posedge clk);
            #1;
        end
        ivalid = 1'b0;
    endtask

    task automatic idleCycles(input int n);
        ivalid = 1'b0;
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    // Results are checked and accepted items scored mid-cycle
    always @(negedge clk) begin
        if (rst && ovalid) begin
            assert (expQ.size() > 0) else begin
                $display("A result came out at %0d ns with no item outstanding", $time);
                $display("tests failed");
                $fatal(1);
            end
            head = expQ.pop_front();
            assert (result == head) else begin
                $display("ERROR at %0d ns: expected count %0d sum %0d, got count %0d sum %0d",
                         $time, head.pcoeffCount, head.summedData,
                         result.pcoeffCount, result.summedData);
                $display("tests failed");
                $fatal(1);
            end
        end
        if (rst && ivalid && oready) begin
            refMask  = formMask(startNewTop, refTop, bot);
            refCount = countComponents(refMask);
            refSum   = addTerm(refSum, startNewTop, refCount);
            if (startNewTop) begin
                refTop = bot;
            end
            pushed.summedData  = refSum;
            pushed.pcoeffCount = countWidth'(refCount);
            expQ.push_back(pushed);
        end
    end

    initial begin
        #(watchdogNs);
        $display("The run timed out after %0d ns before all results came back", watchdogNs);
        $display("tests failed");
        $fatal(1);
    end

    initial begin
        seed        = 95181;
        rst         = 1'b0;
        ivalid      = 1'b0;
        startNewTop = 1'b0;
        bot         = '0;
        refTop      = '0;
        refSum      = '0;
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b1;
        @(negedge clk);
        assert (oready && !ovalid) else begin
            $display("After reset oready was low or ovalid was high");
            $display("tests failed");
            $fatal(1);
        end
        @(posedge clk);
        #1;
        idleCycles(4);                       // ovalid must stay low here

        // Top load and empty graphs
        offerItem(1'b1, '0);
        offerItem(1'b0, '0);
        w = randomWord(2);
        offerItem(1'b1, w);
        offerItem(1'b0, w);                  // Bot equals top, count 0

        // Known shapes
        w    = '0;
        w[0] = 1'b1;
        w[3] = 1'b1;
        w[5] = 1'b1;
        w[6] = 1'b1;
        offerItem(1'b1, w);                  // Four isolated vertices
        offerItem(1'b1, '1);                 // Whole cube
        offerItem(1'b0, '0);
        offerItem(1'b0, parityVertices(1'b1)); // 64 isolated, saturates
        w[9]  = 1'b1;
        w[10] = 1'b1;
        w[12] = 1'b1;
        w[15] = 1'b1;
        offerItem(1'b1, w);                  // Eight isolated vertices

        // Sum restart
        offerItem(1'b0, w);
        offerItem(1'b1, '0);
        offerItem(1'b0, '0);
        idleCycles(5);

        // ivalid held high so the busy counter pushes back
        for (int i = 0; i < burstItems; i++) begin
            r = $random(seed);
            offerItem(i % 8 == 0, randomWord(int'(r[1:0])));
        end

        for (int i = 0; i < randomItems; i++) begin
            r = $random(seed);
            offerItem(r[2:0] == 3'd0, randomWord(int'(r[5:4])));
            if (r[8]) begin
                idleCycles(int'(r[7:6]) + 1);
            end
        end

        idleCycles(1);
        while (expQ.size() != 0) begin
            @(posedge clk);
        end
        repeat (20) @(posedge clk);          // Any stray result trips the scoreboard

        $display("all tests passed");
        $finish;
    end

endmodule

// ==== hw/openCLFullPipeline.sv ====
`timescale 1ns/1ps

module openCLFullPipeline (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              ivalid,
    input  logic                              startNewTop,
    input  logic [dedekindPkg::botWidth-1:0]  bot,
    output logic                              oready,
    output logic                              ovalid,
    output dedekindPkg::pcoeffResult          result
);
    import dedekindPkg::*;

    botItem                item;
    logic                  maskValid;
    maskItem               maskOut;
    logic                  busy;
    logic                  countDone;
    logic [countWidth-1:0] countOut;
    logic                  newTopOut;

    assign item.startNewTop = startNewTop;
    assign item.bot         = bot;

    botIntake u_botIntake (
        .clk       (clk),
        .rst       (rst),
        .ivalid    (ivalid),
        .item      (item),
        .oready    (oready),
        .maskValid (maskValid),
        .maskOut   (maskOut),
        .busy      (busy)
    );

    componentCounter u_componentCounter (
        .clk       (clk),
        .rst       (rst),
        .maskValid (maskValid),
        .maskIn    (maskOut),
        .busy      (busy),
        .countDone (countDone),
        .countOut  (countOut),
        .newTopOut (newTopOut)
    );

    pcoeffAccumulator u_pcoeffAccumulator (
        .clk       (clk),
        .rst       (rst),
        .countDone (countDone),
        .countIn   (countOut),
        .newTop    (newTopOut),
        .ovalid    (ovalid),
        .result    (result)
    );

endmodule

// ==== hw/pcoeffAccumulator.sv ====
`timescale 1ns/1ps

module pcoeffAccumulator (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               countDone,
    input  logic [dedekindPkg::countWidth-1:0] countIn,
    input  logic                               newTop,
    output logic                               ovalid,
    output dedekindPkg::pcoeffResult           result
);
    import dedekindPkg::*;

    logic [sumWidth-1:0] runningSum;         // Sum since the last new top
    logic [sumWidth-1:0] term;
    logic [sumWidth-1:0] nextSum;

    assign term    = sumWidth'(1) << countIn; // 2^count
    assign nextSum = newTop ? term : (runningSum + term);

    always_ff @(posedge clk) begin
        if (!rst) begin
            runningSum <= '0;
            ovalid     <= 1'b0;
        end else begin
            ovalid <= countDone;             // One cycle after countDone
            if (countDone) begin
                runningSum <= nextSum;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (countDone) begin
            result.summedData  <= nextSum;
            result.pcoeffCount <= countIn;
        end
    end

endmodule

// ==== hw/componentCounter.sv ====
`timescale 1ns/1ps

module componentCounter (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                maskValid,
    input  dedekindPkg::maskItem                maskIn,
    output logic                                busy,
    output logic                                countDone,
    output logic [dedekindPkg::countWidth-1:0]  countOut,
    output logic                                newTopOut
);
    import dedekindPkg::*;

    countState             state;
    countState             stateNext;
    logic [botWidth-1:0]   remaining;        // Vertices not yet in a counted component
    logic [botWidth-1:0]   region;           // Component being flooded
    logic [botWidth-1:0]   grown;            // Region after one more hop
    logic [botWidth-1:0]   lowestBit;        // Seed candidate
    logic [botWidth-1:0]   leftOver;         // Remaining once region is removed
    logic [countWidth-1:0] count;
    logic                  newTopReg;        // Flag carried along with the mask
    logic                  regionStable;
    logic                  lastComponent;

    // One hop of flood fill across all cube dimensions
    function automatic logic [botWidth-1:0] growRegion(
        input logic [botWidth-1:0] cur,
        input logic [botWidth-1:0] avail
    );
        logic [botWidth-1:0] next;
        next = cur;
        for (int v = 0; v < botWidth; v++) begin
            for (int d = 0; d < cubeDims; d++) begin
                if (avail[v] && cur[v ^ (1 << d)]) begin
                    next[v] = 1'b1;          // Neighbour differs in bit d only
                end
            end
        end
        return next;
    endfunction

    assign grown         = growRegion(region, remaining);
    assign regionStable  = (grown == region);
    assign leftOver      = remaining & ~region;
    assign lowestBit     = remaining & (~remaining + 1'b1);

    // Stop when the graph is used up or the count saturates
    assign lastComponent = (leftOver == '0) || (count == countWidth'(maxCount - 1));

    always_comb begin
        stateNext = state;
        case (state)
            idle: begin
                if (maskValid) begin
                    stateNext = seed;
                end
            end
            seed: begin
                if (remaining == '0) begin
                    stateNext = finish;      // Empty graph, count stays zero
                end else begin
                    stateNext = expand;
                end
            end
            expand: begin
                if (regionStable) begin
                    stateNext = lastComponent ? finish : seed;
                end
            end
            finish: begin
                stateNext = idle;
            end
            default: begin
                stateNext = idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            state <= idle;
            count <= '0;
        end else begin
            state <= stateNext;
            if (state == idle && maskValid) begin
                count <= '0;
            end else if (state == expand && regionStable) begin
                count <= count + 1'b1;       // Region closed, one more component
            end
        end
    end

    always_ff @(posedge clk) begin
        case (state)
            idle: begin
                if (maskValid) begin
                    remaining <= maskIn.mask;
                    newTopReg <= maskIn.newTop;
                end
            end
            seed: begin
                region <= lowestBit;
            end
            expand: begin
                if (regionStable) begin
                    remaining <= leftOver;
                end else begin
                    region <= grown;
                end
            end
            default: begin
                region <= region;
            end
        endcase
    end

    // Handshake and result straight from registered state
    assign busy      = (state != idle);
    assign countDone = (state == finish);
    assign countOut  = count;
    assign newTopOut = newTopReg;

endmodule

// ==== hw/botIntake.sv ====
`timescale 1ns/1ps

module botIntake (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 ivalid,
    input  dedekindPkg::botItem  item,
    output logic                 oready,
    output logic                 maskValid,
    output dedekindPkg::maskItem maskOut,
    input  logic                 busy
);
    import dedekindPkg::*;

    logic [botWidth-1:0] top;                // Current top word
    logic                holdValid;          // Holding register occupied
    maskItem             holdItem;           // Item waiting for the counter
    logic                accept;
    logic                handOver;
    logic [botWidth-1:0] nextMask;

    // Counter takes the held mask whenever it is idle
    assign handOver = holdValid && !busy;

    // Room when empty or being emptied this cycle
    assign oready = !holdValid || handOver;
    assign accept = ivalid && oready;

    // A new top is its own graph
    assign nextMask = item.startNewTop ? item.bot : (top & ~item.bot);

    always_ff @(posedge clk) begin
        if (!rst) begin
            top       <= '0;
            holdValid <= 1'b0;
        end else begin
            if (accept && item.startNewTop) begin
                top <= item.bot;
            end
            if (accept) begin
                holdValid <= 1'b1;
            end else if (handOver) begin
                holdValid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            holdItem.newTop <= item.startNewTop;
            holdItem.mask   <= nextMask;
        end
    end

    assign maskValid = holdValid;
    assign maskOut   = holdItem;

endmodule

// ==== hw/dedekindPkg.sv ====
package dedekindPkg;

    // Bot and top words index the vertices of a 7-cube
    localparam int botWidth   = 128;         // One bit per hypercube vertex
    localparam int cubeDims   = 7;           // Vertex index width
    localparam int countWidth = 3;           // pcoeffCount width
    localparam int maxCount   = 7;           // Saturation point, means seven or more
    localparam int sumWidth   = 38;          // Running sum of 2^count per top

    // One item as offered on the kernel input
    typedef struct packed {
        logic                startNewTop;    // Bot word becomes the new top
        logic [botWidth-1:0] bot;
    } botItem;

    // Vertex set handed from intake to the counter
    typedef struct packed {
        logic                newTop;         // Restarts the running sum downstream
        logic [botWidth-1:0] mask;           // Vertices set in top and clear in bot
    } maskItem;

    // One result leaving the pipeline
    typedef struct packed {
        logic [sumWidth-1:0]   summedData;
        logic [countWidth-1:0] pcoeffCount;
    } pcoeffResult;

    // Flood fill FSM of the component counter
    typedef enum logic [1:0] {
        idle   = 2'd0,                       // Waiting for a mask
        seed   = 2'd1,                       // Pick lowest remaining vertex
        expand = 2'd2,                       // Grow region one hop per cycle
        finish = 2'd3                        // Count is final
    } countState;

endpackage
